/* verilog.f */
verilog/jalr_pkg.sv
verilog/cdb_if.sv
verilog/jalr_head_if.sv
verilog/jalr_queue.sv
verilog/jalr_resolve.sv
verilog/jalr_csr.sv
verilog/jalr_unit.sv
tests/jalr_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the jalr_unit simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module jalr_unit_tb -o jalr_unit_sim

# The simulator exits non-zero on a failed check, the log decides the outcome
./obj_dir/jalr_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
else
    exit 1
fi

/* tests/jalr_unit_tb.sv */
// Testbench for the jump-register resolution unit
// Stimulus table of JALRs, dispatch credit model, result and register checks

`timescale 1ns/1ns

module jalr_unit_tb;

    typedef struct {
        string               name;
        jalr_pkg::rob_tag_t  src_tag;
        logic [31:0]         base;
        logic [31:0]         imm;
        logic [31:0]         pred;
        // Broadcast cycles after enqueue, -1 for none
        int                  cdb_dly;
        jalr_pkg::rob_tag_t  cdb_tag;
        logic [31:0]         cdb_value;
        logic                cdb_step1;
        int                  commit_dly;
        logic                align;
        logic [31:0]         exp_target;
        logic                exp_mis;
    } row_t;

    logic                    clk;
    logic                    reset;
    logic                    enq_valid;
    jalr_pkg::jalr_entry_t   enq_entry;
    logic                    cdb_valid;
    jalr_pkg::rob_tag_t      cdb_tag;
    logic [31:0]             cdb_result;
    logic                    cdb_load_step1;
    logic                    commit;
    logic                    cfg_wr_en;
    logic [1:0]              cfg_addr;
    logic [31:0]             cfg_wdata;
    logic [31:0]             cfg_rdata;
    logic                    resolve_valid;
    jalr_pkg::jalr_result_t  result;
    logic                    credit_return;

    row_t         rows[$];
    int           depth;
    int           enq_count;
    int           ret_count;
    int           res_count;
    int           mis_count;
    logic [31:0]  lcg_state;
    logic [31:0]  rd_data;

    jalr_unit i_jalr_unit (
        .clk (clk), .reset (reset),
        .enq_valid (enq_valid), .enq_entry (enq_entry),
        .cdb_valid (cdb_valid), .cdb_tag (cdb_tag),
        .cdb_result (cdb_result), .cdb_load_step1 (cdb_load_step1),
        .commit (commit),
        .cfg_wr_en (cfg_wr_en), .cfg_addr (cfg_addr),
        .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata),
        .resolve_valid (resolve_valid), .result (result),
        .credit_return (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_result(input string name, input jalr_pkg::jalr_result_t exp,
                                input jalr_pkg::jalr_result_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Target rule: base + imm, bit 0 cleared when aligning
    function automatic logic [31:0] rule_target(input logic [31:0] base,
                                                input logic [31:0] imm, input logic align);
        logic [31:0] sum;
        sum = base + imm;
        if (align) begin
            sum[0] = 1'b0;
        end
        return sum;
    endfunction

    function automatic jalr_pkg::rob_tag_t tag_of(input int k);
        return jalr_pkg::rob_tag_t'((k % 15) + 1);
    endfunction

    function automatic int credits_left();
        return depth - enq_count + ret_count;
    endfunction

    function automatic jalr_pkg::jalr_entry_t make_entry(input int k);
        jalr_pkg::jalr_entry_t e;
        e.valid = 1'b1;
        e.src_tag = rows[k].src_tag;
        // Waiting entries carry a stale base that the CDB must replace
        e.base = (rows[k].src_tag == '0) ? rows[k].base : ~rows[k].base;
        e.imm = rows[k].imm;
        e.predicted_target = rows[k].pred;
        e.rob_tag = tag_of(k);
        return e;
    endfunction

    task automatic add_row(input string name, input logic [3:0] src_tag,
                           input logic [31:0] base, input logic [31:0] imm,
                           input logic [31:0] pred, input int cdb_dly,
                           input logic [3:0] c_tag, input logic [31:0] c_value,
                           input logic c_step1, input int commit_dly, input logic align,
                           input logic [31:0] exp_target, input logic exp_mis);
        row_t r;
        r.name = name;
        r.src_tag = src_tag;
        r.base = base;
        r.imm = imm;
        r.pred = pred;
        r.cdb_dly = cdb_dly;
        r.cdb_tag = c_tag;
        r.cdb_value = c_value;
        r.cdb_step1 = c_step1;
        r.commit_dly = commit_dly;
        r.align = align;
        r.exp_target = exp_target;
        r.exp_mis = exp_mis;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] base;
        logic [31:0] target;
        add_row("ready_hit", 4'd0, 32'h0000_1000, 32'h0000_0024, 32'h0000_1024,
                -1, 4'd0, 32'h0, 1'b0, 0, 1'b1, 32'h0000_1024, 1'b0);
        add_row("ready_odd_align", 4'd0, 32'h0000_2001, 32'h0000_0010, 32'h0000_2010,
                -1, 4'd0, 32'h0, 1'b0, 1, 1'b1, 32'h0000_2010, 1'b0);
        add_row("ready_miss", 4'd0, 32'h0000_3000, 32'hffff_fffc, 32'h0000_3000,
                -1, 4'd0, 32'h0, 1'b0, 0, 1'b1, 32'h0000_2ffc, 1'b1);
        add_row("wait_cdb", 4'd5, 32'h4000_0000, 32'h0000_0008, 32'h4000_0008,
                3, 4'd5, 32'h4000_0000, 1'b0, 0, 1'b1, 32'h4000_0008, 1'b0);
        add_row("bypass_cdb", 4'd6, 32'h5555_0000, 32'h0000_0103, 32'h5555_0102,
                0, 4'd6, 32'h5555_0000, 1'b0, 0, 1'b1, 32'h5555_0102, 1'b0);
        // Partial load results must not wake the entry
        add_row("step1_no_wake", 4'd7, 32'h6000_0040, 32'h0000_0040, 32'h6000_0090,
                1, 4'd7, 32'h0bad_0000, 1'b1, 0, 1'b1, 32'h6000_0080, 1'b1);
        add_row("step1_bypass", 4'd8, 32'h7000_0000, 32'h0000_0001, 32'h7000_0000,
                0, 4'd8, 32'h0bad_0001, 1'b1, 0, 1'b1, 32'h7000_0000, 1'b0);
        add_row("other_tag", 4'd9, 32'h0800_0100, 32'hffff_ff00, 32'h0800_0000,
                2, 4'd10, 32'h0bad_0002, 1'b0, 0, 1'b1, 32'h0800_0000, 1'b0);
        // Late commit lets the queue fill and drains the credits
        add_row("slow_commit", 4'd0, 32'h0000_8000, 32'h0000_0044, 32'h0000_8044,
                -1, 4'd0, 32'h0, 1'b0, 20, 1'b1, 32'h0000_8044, 1'b0);
        for (int i = 0; i < 6; i++) begin
            lcg_state = lcg_next(lcg_state);
            base = lcg_state;
            target = rule_target(base, 32'h0000_0101, 1'b1);
            add_row($sformatf("lcg_%0d", i), 4'd0, base, 32'h0000_0101,
                    (i % 2 == 0) ? target : target + 32'd4, -1, 4'd0, 32'h0, 1'b0, 0,
                    1'b1, target, i % 2 == 1);
        end
        add_row("noalign_odd", 4'd0, 32'h0000_9001, 32'h0000_0010, 32'h0000_9011,
                -1, 4'd0, 32'h0, 1'b0, 0, 1'b0, 32'h0000_9011, 1'b0);
        add_row("noalign_miss", 4'd3, 32'h0000_a000, 32'h0000_0005, 32'h0000_a004,
                2, 4'd3, 32'h0000_a000, 1'b0, 0, 1'b0, 32'h0000_a005, 1'b1);
    endtask

    task automatic drive_cdb(input logic [3:0] tag, input logic [31:0] value,
                             input logic step1);
        cdb_valid <= 1'b1;
        cdb_tag <= tag;
        cdb_result <= value;
        cdb_load_step1 <= step1;
    endtask

    task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        cfg_wr_en <= 1'b1;
        cfg_addr <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr_en <= 1'b0;
    endtask

    task automatic reg_read(input logic [1:0] addr, output logic [31:0] data);
        @(posedge clk);
        cfg_wr_en <= 1'b0;
        cfg_addr <= addr;
        @(posedge clk);
        data = cfg_rdata;
    endtask

    task automatic run_dispatch();
        logic cur_align;
        logic wakes;
        cur_align = 1'b1;
        for (int k = 0; k < rows.size(); k++) begin
            wakes = (rows[k].cdb_dly >= 0) && !rows[k].cdb_step1 &&
                    (rows[k].cdb_tag == rows[k].src_tag);
            if (rows[k].align != cur_align) begin
                // Older jumps resolve under the old setting
                wait (res_count == k);
                reg_write(jalr_pkg::ctrl_addr, {31'b0, rows[k].align});
                cur_align = rows[k].align;
            end
            @(posedge clk);
            while (credits_left() == 0) begin
                @(posedge clk);
            end
            enq_valid <= 1'b1;
            enq_entry <= make_entry(k);
            enq_count <= enq_count + 1;
            if (rows[k].cdb_dly == 0) begin
                drive_cdb(rows[k].cdb_tag, rows[k].cdb_value, rows[k].cdb_step1);
            end
            @(posedge clk);
            enq_valid <= 1'b0;
            cdb_valid <= 1'b0;
            if (rows[k].cdb_dly > 0) begin
                repeat (rows[k].cdb_dly - 1) @(posedge clk);
                drive_cdb(rows[k].cdb_tag, rows[k].cdb_value, rows[k].cdb_step1);
                @(posedge clk);
                cdb_valid <= 1'b0;
            end
            // Final result for an entry still waiting
            if (rows[k].src_tag != '0 && !wakes) begin
                repeat (2) @(posedge clk);
                drive_cdb(rows[k].src_tag, rows[k].base, 1'b0);
                @(posedge clk);
                cdb_valid <= 1'b0;
            end
        end
    endtask

    task automatic run_commit();
        jalr_pkg::jalr_result_t exp;
        int waited;
        for (int k = 0; k < rows.size(); k++) begin
            wait (enq_count > k);
            repeat (rows[k].commit_dly) @(posedge clk);
            @(posedge clk);
            commit <= 1'b1;
            waited = 0;
            @(posedge clk);
            while (!resolve_valid && waited < 60) begin
                @(posedge clk);
                waited++;
            end
            if (!resolve_valid) begin
                fail_run($sformatf("%s did not resolve within 60 cycles", rows[k].name));
            end
            commit <= 1'b0;
            exp.rob_tag = tag_of(k);
            exp.target = rows[k].exp_target;
            exp.mispredict = rows[k].exp_mis;
            check_result(rows[k].name, exp, result);
            res_count++;
            if (rows[k].exp_mis) begin
                mis_count++;
            end
        end
    endtask

    // Credit model, a return without an outstanding entry is an error
    always @(posedge clk) begin
        if (!reset && credit_return) begin
            if (ret_count >= enq_count) begin
                fail_run("credit returned with no entry outstanding");
            end else begin
                ret_count <= ret_count + 1;
            end
        end
    end

    initial begin
        @(negedge reset);
        repeat (rows.size() * 40) @(posedge clk);
        fail_run("watchdog expired before all jumps retired");
    end

    initial begin
        reset = 1'b1;
        enq_valid = 1'b0;
        enq_entry = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        cdb_result = '0;
        cdb_load_step1 = 1'b0;
        commit = 1'b0;
        cfg_wr_en = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        enq_count = 0;
        ret_count = 0;
        res_count = 0;
        mis_count = 0;
        lcg_state = 32'd84;
        depth = i_jalr_unit.DEPTH;
        build_table();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        fork
            run_dispatch();
            run_commit();
        join
        repeat (2) @(posedge clk);
        // Every enqueue must come back as exactly one credit
        check_word("credit_total", 32'(enq_count), 32'(ret_count));
        reg_read(jalr_pkg::resolved_addr, rd_data);
        check_word("resolved_count", 32'(rows.size()), rd_data);
        reg_read(jalr_pkg::mispredict_addr, rd_data);
        check_word("mispredict_count", 32'(mis_count), rd_data);
        reg_read(jalr_pkg::ctrl_addr, rd_data);
        check_word("ctrl_readback", 32'h0, rd_data);
        reg_write(jalr_pkg::resolved_addr, 32'h0);
        reg_read(jalr_pkg::resolved_addr, rd_data);
        check_word("resolved_clear", 32'h0, rd_data);
        reg_write(jalr_pkg::mispredict_addr, 32'h0);
        reg_read(jalr_pkg::mispredict_addr, rd_data);
        check_word("mispredict_clear", 32'h0, rd_data);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* verilog/jalr_unit.sv */
// Jump-register resolution unit top level
// Queue, commit-time resolver and register block on plain ports

`timescale 1ns/1ns

module jalr_unit #(
    parameter int DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        enq_valid,
    input  jalr_pkg::jalr_entry_t       enq_entry,
    input  logic                        cdb_valid,
    input  jalr_pkg::rob_tag_t          cdb_tag,
    input  logic [jalr_pkg::xlen-1:0]   cdb_result,
    input  logic                        cdb_load_step1,
    input  logic                        commit,
    input  logic                        cfg_wr_en,
    input  logic [1:0]                  cfg_addr,
    input  logic [31:0]                 cfg_wdata,
    output logic [31:0]                 cfg_rdata,
    output logic                        resolve_valid,
    output jalr_pkg::jalr_result_t      result,
    output logic                        credit_return
);

    logic align_enable;

    cdb_if       i_cdb ();
    jalr_head_if i_head ();

    // Broadcast from the core's CDB
    assign i_cdb.valid      = cdb_valid;
    assign i_cdb.tag        = cdb_tag;
    assign i_cdb.result     = cdb_result;
    assign i_cdb.load_step1 = cdb_load_step1;

    jalr_queue #(
        .DEPTH (DEPTH)
    ) i_jalr_queue (
        .clk           (clk),
        .reset         (reset),
        .enq_valid     (enq_valid),
        .enq_entry     (enq_entry),
        .cdb           (i_cdb.snooper),
        .head          (i_head.queue),
        .credit_return (credit_return)
    );

    jalr_resolve i_jalr_resolve (
        .clk           (clk),
        .reset         (reset),
        .head          (i_head.resolver),
        .commit        (commit),
        .align_enable  (align_enable),
        .resolve_valid (resolve_valid),
        .result        (result)
    );

    jalr_csr i_jalr_csr (
        .clk           (clk),
        .reset         (reset),
        .cfg_wr_en     (cfg_wr_en),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .resolve_valid (resolve_valid),
        .mispredict    (result.mispredict),
        .align_enable  (align_enable)
    );

endmodule

/* verilog/jalr_csr.sv */
// Control register and jump event counters
// Write port clears counters, reads are combinational

`timescale 1ns/1ns

module jalr_csr (
    input  logic         clk,
    input  logic         reset,
    input  logic         cfg_wr_en,
    input  logic [1:0]   cfg_addr,
    input  logic [31:0]  cfg_wdata,
    output logic [31:0]  cfg_rdata,
    input  logic         resolve_valid,
    input  logic         mispredict,
    output logic         align_enable
);

    logic [31:0]  resolved_count;
    logic [31:0]  mispredict_count;

    // Control bit, aligned targets by default
    always_ff @(posedge clk) begin
        if (reset) begin
            align_enable <= 1'b1;
        end else if (cfg_wr_en && cfg_addr == jalr_pkg::ctrl_addr) begin
            align_enable <= cfg_wdata[0];
        end
    end

    // Saturating counters, a write clears and wins over an event
    always_ff @(posedge clk) begin
        if (reset) begin
            resolved_count <= '0;
            mispredict_count <= '0;
        end else begin
            if (cfg_wr_en && cfg_addr == jalr_pkg::resolved_addr) begin
                resolved_count <= '0;
            end else if (resolve_valid && resolved_count != '1) begin
                resolved_count <= resolved_count + 32'd1;
            end
            if (cfg_wr_en && cfg_addr == jalr_pkg::mispredict_addr) begin
                mispredict_count <= '0;
            end else if (resolve_valid && mispredict && mispredict_count != '1) begin
                mispredict_count <= mispredict_count + 32'd1;
            end
        end
    end

    // Read mux
    always_comb begin
        case (cfg_addr)
            jalr_pkg::ctrl_addr:       cfg_rdata = {31'b0, align_enable};
            jalr_pkg::resolved_addr:   cfg_rdata = resolved_count;
            jalr_pkg::mispredict_addr: cfg_rdata = mispredict_count;
            default:                   cfg_rdata = '0;
        endcase
    end

endmodule

/* verilog/jalr_resolve.sv */
// Commit-time resolution of the oldest JALR
// Forms base + imm, optionally aligned, and flags a mispredict

`timescale 1ns/1ns

module jalr_resolve (
    input  logic                    clk,
    input  logic                    reset,
    jalr_head_if.resolver           head,
    input  logic                    commit,
    input  logic                    align_enable,
    output logic                    resolve_valid,
    output jalr_pkg::jalr_result_t  result
);

    logic [jalr_pkg::xlen-1:0]  sum;
    logic [jalr_pkg::xlen-1:0]  target;
    logic                       busy;

    // One pop per commit request
    assign head.pop = commit && !busy && head.head_valid && head.head_ready;

    assign sum    = head.head.base + head.head.imm;
    assign target = {sum[jalr_pkg::xlen-1:1], sum[0] & ~align_enable};

    // Busy until the commit request is withdrawn
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            resolve_valid <= 1'b0;
        end else begin
            busy <= head.pop || (busy && commit);
            resolve_valid <= head.pop;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (head.pop) begin
            result.rob_tag    <= head.head.rob_tag;
            result.target     <= target;
            result.mispredict <= (target != head.head.predicted_target);
        end
    end

endmodule

/* verilog/jalr_queue.sv */
// In-order queue of pending JALRs
// Snoops the CDB for missing base values, bypasses a same-cycle broadcast
// and returns one dispatch credit per popped entry

`timescale 1ns/1ns

module jalr_queue #(
    parameter int DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enq_valid,
    input  jalr_pkg::jalr_entry_t  enq_entry,
    cdb_if.snooper                 cdb,
    jalr_head_if.queue             head,
    output logic                   credit_return
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    jalr_pkg::jalr_entry_t  slots [DEPTH];
    jalr_pkg::cdb_word_t    bus;
    jalr_pkg::jalr_entry_t  enq_word;

    logic [PTR_W-1:0]  wptr;
    logic [PTR_W-1:0]  rptr;
    logic [CNT_W-1:0]  count;
    logic              wake;

    // Collect the snooped broadcast into one word
    assign bus = '{
        valid:      cdb.valid,
        tag:        cdb.tag,
        result:     cdb.result,
        load_step1: cdb.load_step1
    };

    // Only final results wake a waiting entry
    assign wake = bus.valid && !bus.load_step1;

    // Bypass a broadcast that arrives together with the entry
    always_comb begin
        enq_word = enq_entry;
        if (wake && enq_entry.src_tag != '0 && enq_entry.src_tag == bus.tag) begin
            enq_word.base    = bus.result;
            enq_word.src_tag = '0;
        end
    end

    // Entry storage with CDB capture
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (wake && slots[i].valid && slots[i].src_tag != '0 &&
                slots[i].src_tag == bus.tag) begin
                slots[i].base    <= bus.result;
                slots[i].src_tag <= '0;
            end
        end
        // Write slot is free, so the new entry takes priority
        if (enq_valid) begin
            slots[wptr] <= enq_word;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
        end else begin
            if (enq_valid) begin
                wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + PTR_W'(1);
            end
            if (head.pop) begin
                rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + PTR_W'(1);
            end
            case ({enq_valid, head.pop})
                2'b10: count <= count + CNT_W'(1);
                2'b01: count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // One credit back per retired entry
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= head.pop;
        end
    end

    // Head view for the resolver
    assign head.head       = slots[rptr];
    assign head.head_valid = (count != '0);
    assign head.head_ready = head.head_valid && (slots[rptr].src_tag == '0);

endmodule

/* verilog/jalr_head_if.sv */
// Handshake between the queue head and the resolver
// Queue presents the oldest entry, resolver pops it

`timescale 1ns/1ns

interface jalr_head_if;

    logic                   head_valid;
    // Not empty and base operand present
    logic                   head_ready;
    jalr_pkg::jalr_entry_t  head;
    // Only while head_ready, entry leaves at the edge
    logic                   pop;

    modport queue (
        output head_valid,
        output head_ready,
        output head,
        input  pop
    );

    modport resolver (
        input  head_valid,
        input  head_ready,
        input  head,
        output pop
    );

endinterface

/* verilog/cdb_if.sv */
// Common data bus interface
// Source side drives a broadcast, snoopers only listen

`timescale 1ns/1ns

interface cdb_if;

    // Single-cycle broadcast, no back-pressure
    logic                         valid;
    jalr_pkg::rob_tag_t           tag;
    logic [jalr_pkg::xlen-1:0]    result;
    logic                         load_step1;

    modport source (
        output valid,
        output tag,
        output result,
        output load_step1
    );

    modport snooper (
        input  valid,
        input  tag,
        input  result,
        input  load_step1
    );

endinterface

/* verilog/jalr_pkg.sv */
// Shared types for the jump-register resolution unit
// Queue entry, CDB broadcast word and resolution result
// Register addresses of the control and counter block

package jalr_pkg;

    // Data and address width
    localparam int xlen = 32;

    // Reorder-buffer tag, 0 means the value is already present
    typedef logic [3:0] rob_tag_t;

    // One pending JALR as held in the queue
    typedef struct packed {
        logic             valid;
        rob_tag_t         src_tag;
        logic [xlen-1:0]  base;
        logic [xlen-1:0]  imm;
        logic [xlen-1:0]  predicted_target;
        rob_tag_t         rob_tag;
    } jalr_entry_t;

    // One broadcast on the common data bus
    typedef struct packed {
        logic             valid;
        rob_tag_t         tag;
        logic [xlen-1:0]  result;
        // First half of a split load, result not final yet
        logic             load_step1;
    } cdb_word_t;

    // Outcome of one resolved jump
    typedef struct packed {
        rob_tag_t         rob_tag;
        logic [xlen-1:0]  target;
        logic             mispredict;
    } jalr_result_t;

    // Register map
    localparam logic [1:0] ctrl_addr       = 2'd0;
    localparam logic [1:0] resolved_addr   = 2'd1;
    localparam logic [1:0] mispredict_addr = 2'd2;

endpackage
